//--- source/tile_settings.svh
`ifndef TILE_SETTINGS_SVH
`define TILE_SETTINGS_SVH

// ##########################################################
// Tile build settings
// ##########################################################

// Clock cycles per serial bit, even and at least 4
`define CLKS_PER_BIT 8

`define TX_DEPTH 4      // Entries in the outgoing flit queue

`define NODE_ID 2'd1    // Address of this tile

`endif

//--- source/phy_pkg.sv
package phy_pkg;

    // ##########################################################
    // Serial framing states
    // ##########################################################

    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,
        RX_START = 2'd1,   // Waiting for mid-start sample
        RX_DATA  = 2'd2,
        RX_STOP  = 2'd3
    } rx_state_e;

endpackage

//--- source/noc_pkg.sv
package noc_pkg;

    typedef enum logic [1:0] {
        OP_WRITE  = 2'd0,
        OP_READ   = 2'd1,
        OP_RESP   = 2'd2,
        OP_NOTIFY = 2'd3
    } flit_op_e;

    typedef logic [1:0]  node_id_t;
    typedef logic [11:0] payload_t;

    // Opcode in the top bits, then destination, then payload
    typedef struct packed {
        flit_op_e op;
        node_id_t dest;
        payload_t payload;
    } flit_t;

endpackage

//--- source/baud_timer.sv
`include "tile_settings.svh"

module baud_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic tx_run,
    input  logic rx_run,
    input  logic rx_start,
    output logic tx_tick,
    output logic rx_tick
);
    localparam int CNT_W = $clog2(`CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF = CNT_W'(`CLKS_PER_BIT / 2 - 1);

    logic [CNT_W-1:0] tx_cnt;
    logic [CNT_W-1:0] rx_cnt;

    // Transmit counter counts up, held at zero while idle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_cnt <= '0;
        end else if (!tx_run || tx_cnt == LAST) begin
            tx_cnt <= '0;
        end else begin
            tx_cnt <= tx_cnt + 1'b1;
        end
    end

    // Receive counter counts down from a half period after the edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_cnt <= '0;
        end else if (rx_start) begin
            rx_cnt <= HALF;
        end else if (rx_run) begin
            rx_cnt <= (rx_cnt == '0) ? LAST : rx_cnt - 1'b1;
        end
    end

    assign tx_tick = tx_run && (tx_cnt == LAST);
    assign rx_tick = rx_run && (rx_cnt == '0);   // Mid-bit sample point
endmodule

//--- source/link_ctrl.sv
module link_ctrl import phy_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      byte_send,
    input  logic      tx_tick,
    input  logic      rx_tick,
    input  logic      rx_line,
    output logic      tx_run,
    output logic      rx_run,
    output logic      rx_start,
    output tx_state_e tx_state,
    output rx_state_e rx_state,
    output logic      byte_sent,
    output logic      byte_rcvd,
    output logic      frame_err
);
    logic [2:0] tx_idx;
    logic [2:0] rx_idx;
    logic       rx_line_q;   // Previous line level for edge detect

    // ##########################################################
    // Transmit framing
    // ##########################################################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_state <= TX_IDLE;
            tx_idx   <= '0;
        end else begin
            case (tx_state)
                TX_IDLE:  if (byte_send) tx_state <= TX_START;
                TX_START: if (tx_tick) begin
                    tx_state <= TX_DATA;
                    tx_idx   <= '0;
                end
                TX_DATA:  if (tx_tick) begin
                    if (tx_idx == 3'd7) tx_state <= TX_STOP;
                    tx_idx <= tx_idx + 1'b1;
                end
                TX_STOP:  if (tx_tick) tx_state <= TX_IDLE;
                default:  tx_state <= TX_IDLE;
            endcase
        end
    end

    // ##########################################################
    // Receive framing
    // ##########################################################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_state  <= RX_IDLE;
            rx_idx    <= '0;
            rx_line_q <= 1'b1;
        end else begin
            rx_line_q <= rx_line;
            case (rx_state)
                RX_IDLE:  if (rx_start) rx_state <= RX_START;
                RX_START: if (rx_tick) begin
                    rx_state <= rx_line ? RX_IDLE : RX_DATA;   // Glitch reject
                    rx_idx   <= '0;
                end
                RX_DATA:  if (rx_tick) begin
                    if (rx_idx == 3'd7) rx_state <= RX_STOP;
                    rx_idx <= rx_idx + 1'b1;
                end
                RX_STOP:  if (rx_tick) rx_state <= RX_IDLE;
                default:  rx_state <= RX_IDLE;
            endcase
        end
    end

    assign rx_start  = (rx_state == RX_IDLE) && rx_line_q && !rx_line;
    assign tx_run    = (tx_state != TX_IDLE);
    assign rx_run    = (rx_state != RX_IDLE);
    assign byte_sent = (tx_state == TX_STOP) && tx_tick;
    assign byte_rcvd = (rx_state == RX_STOP) && rx_tick && rx_line;
    assign frame_err = (rx_state == RX_STOP) && rx_tick && !rx_line;
endmodule

//--- source/byte_shifter.sv
module byte_shifter import phy_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] byte_out,
    input  logic       byte_send,
    input  tx_state_e  tx_state,
    input  logic       tx_tick,
    input  rx_state_e  rx_state,
    input  logic       rx_tick,
    input  logic       uart_rx,
    output logic       rx_line,
    output logic       uart_tx,
    output logic [7:0] byte_in
);
    logic [7:0] tx_shreg;
    logic [7:0] rx_shreg;
    logic       rx_meta;

    // Transmit register, LSB goes out first
    always_ff @(posedge clk) begin
        if (tx_state == TX_IDLE && byte_send) begin
            tx_shreg <= byte_out;
        end else if (tx_state == TX_DATA && tx_tick) begin
            tx_shreg <= {1'b0, tx_shreg[7:1]};
        end
    end

    always_comb begin
        case (tx_state)
            TX_START: uart_tx = 1'b0;
            TX_DATA:  uart_tx = tx_shreg[0];
            default:  uart_tx = 1'b1;   // Idle and stop are high
        endcase
    end

    // Line synchronizer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_line <= 1'b1;
        end else begin
            rx_meta <= uart_rx;
            rx_line <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_state == RX_DATA && rx_tick) rx_shreg <= {rx_line, rx_shreg[7:1]};
    end

    assign byte_in = rx_shreg;
endmodule

//--- source/flit_codec.sv
module flit_codec import noc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flit_send,
    input  flit_t      flit_out,
    output logic       codec_busy,
    output logic       byte_send,
    output logic [7:0] byte_out,
    input  logic       byte_sent,
    input  logic       byte_rcvd,
    input  logic [7:0] byte_in,
    input  logic       frame_err,
    output logic       flit_rcvd,
    output flit_t      flit_in,
    output logic       chk_err
);
    logic [15:0] tx_flit;
    logic [1:0]  tx_sel;    // 0 upper, 1 lower, 2 checksum
    logic        tx_busy;
    logic [1:0]  rx_cnt;
    logic [7:0]  rx_hi;
    logic [7:0]  rx_lo;

    // ##########################################################
    // Transmit side
    // ##########################################################
    always_ff @(posedge clk) begin
        if (flit_send && !tx_busy) tx_flit <= flit_out;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_busy   <= 1'b0;
            tx_sel    <= '0;
            byte_send <= 1'b0;
        end else begin
            byte_send <= 1'b0;
            if (flit_send && !tx_busy) begin
                tx_busy   <= 1'b1;
                tx_sel    <= '0;
                byte_send <= 1'b1;
            end else if (tx_busy && byte_sent) begin
                if (tx_sel == 2'd2) begin
                    tx_busy <= 1'b0;
                end else begin
                    tx_sel    <= tx_sel + 1'b1;
                    byte_send <= 1'b1;   // One cycle hand-off
                end
            end
        end
    end

    always_comb begin
        case (tx_sel)
            2'd0:    byte_out = tx_flit[15:8];
            2'd1:    byte_out = tx_flit[7:0];
            default: byte_out = tx_flit[15:8] ^ tx_flit[7:0];
        endcase
    end

    assign codec_busy = tx_busy;

    // ##########################################################
    // Receive side
    // ##########################################################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_cnt    <= '0;
            flit_rcvd <= 1'b0;
            chk_err   <= 1'b0;
        end else begin
            flit_rcvd <= 1'b0;
            chk_err   <= 1'b0;
            if (frame_err) begin
                rx_cnt <= '0;   // Resync on the next byte
            end else if (byte_rcvd) begin
                case (rx_cnt)
                    2'd0: rx_cnt <= 2'd1;
                    2'd1: rx_cnt <= 2'd2;
                    default: begin
                        rx_cnt <= '0;
                        if (byte_in == (rx_hi ^ rx_lo)) flit_rcvd <= 1'b1;
                        else chk_err <= 1'b1;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_rcvd && rx_cnt == 2'd0) rx_hi <= byte_in;
        if (byte_rcvd && rx_cnt == 2'd1) rx_lo <= byte_in;
        if (byte_rcvd && rx_cnt == 2'd2) flit_in <= flit_t'({rx_hi, rx_lo});
    end
endmodule

//--- source/endpoint.sv
`include "tile_settings.svh"

module endpoint import noc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_valid,
    input  flit_op_e   tx_op,
    input  node_id_t   tx_dest,
    input  payload_t   tx_payload,
    output logic       tx_full,
    input  logic       codec_busy,
    output logic       flit_send,
    output flit_t      flit_out,
    input  logic       flit_rcvd,
    input  flit_t      flit_in,
    output logic       rx_valid,
    output flit_op_e   rx_op,
    output node_id_t   rx_dest,
    output payload_t   rx_payload,
    output logic [7:0] drop_count
);
    localparam int PTR_W = $clog2(`TX_DEPTH);
    localparam int CNT_W = $clog2(`TX_DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`TX_DEPTH - 1);

    flit_t            queue [`TX_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign tx_full = (count == CNT_W'(`TX_DEPTH));
    assign push    = tx_valid && !tx_full;
    assign pop     = (count != '0) && !codec_busy && !tx_valid;   // Bus writes first

    always_ff @(posedge clk) begin
        if (push) queue[wr_ptr] <= '{op: tx_op, dest: tx_dest, payload: tx_payload};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    assign flit_send = pop;
    assign flit_out  = queue[rd_ptr];

    // Address filter on received flits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_valid   <= 1'b0;
            drop_count <= '0;
        end else begin
            rx_valid <= flit_rcvd && (flit_in.dest == `NODE_ID);
            if (flit_rcvd && flit_in.dest != `NODE_ID && drop_count != 8'hff) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flit_rcvd) begin
            rx_op      <= flit_in.op;
            rx_dest    <= flit_in.dest;
            rx_payload <= flit_in.payload;
        end
    end
endmodule

//--- source/tile.sv
module tile import noc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       uart_rx,
    output logic       uart_tx,
    input  logic       tx_valid,
    input  flit_op_e   tx_op,
    input  node_id_t   tx_dest,
    input  payload_t   tx_payload,
    output logic       tx_full,
    output logic       rx_valid,
    output flit_op_e   rx_op,
    output node_id_t   rx_dest,
    output payload_t   rx_payload,
    output logic       chk_err,
    output logic       frame_err,
    output logic [7:0] drop_count
);
    logic tx_run, rx_run, rx_start, tx_tick, rx_tick, rx_line;
    logic byte_send, byte_sent, byte_rcvd;
    logic [7:0] byte_out, byte_in;
    logic codec_busy, flit_send, flit_rcvd;
    flit_t flit_out, flit_in;
    phy_pkg::tx_state_e tx_state;
    phy_pkg::rx_state_e rx_state;

    // ##########################################################
    // Serial link
    // ##########################################################
    baud_timer i_baud_timer (.clk, .rst_n, .tx_run, .rx_run, .rx_start, .tx_tick, .rx_tick);

    link_ctrl i_link_ctrl (
        .clk, .rst_n, .byte_send, .tx_tick, .rx_tick, .rx_line,
        .tx_run, .rx_run, .rx_start, .tx_state, .rx_state,
        .byte_sent, .byte_rcvd, .frame_err
    );

    byte_shifter i_byte_shifter (
        .clk, .rst_n, .byte_out, .byte_send, .tx_state, .tx_tick,
        .rx_state, .rx_tick, .uart_rx, .rx_line, .uart_tx, .byte_in
    );

    // Framing and local endpoint
    flit_codec i_flit_codec (
        .clk, .rst_n, .flit_send, .flit_out, .codec_busy, .byte_send, .byte_out,
        .byte_sent, .byte_rcvd, .byte_in, .frame_err, .flit_rcvd, .flit_in, .chk_err
    );

    endpoint i_endpoint (
        .clk, .rst_n, .tx_valid, .tx_op, .tx_dest, .tx_payload, .tx_full,
        .codec_busy, .flit_send, .flit_out, .flit_rcvd, .flit_in,
        .rx_valid, .rx_op, .rx_dest, .rx_payload, .drop_count
    );
endmodule

//--- test/tile_tb.sv
`include "tile_settings.svh"

module tile_tb import noc_pkg::*; ();
    localparam int FLIT_TIMEOUT = 40 * `CLKS_PER_BIT;   // Cycles allowed per flit

    logic       clk = 1'b0;
    logic       rst_n;
    logic       uart_rx;
    logic       uart_tx;
    logic       serial_line;   // Driven by the serial byte task
    logic       loopback;
    logic       tx_valid;
    flit_op_e   tx_op;
    node_id_t   tx_dest;
    payload_t   tx_payload;
    logic       tx_full;
    logic       rx_valid;
    flit_op_e   rx_op;
    node_id_t   rx_dest;
    payload_t   rx_payload;
    logic       chk_err;
    logic       frame_err;
    logic [7:0] drop_count;

    flit_t      rx_q [$];      // Flits seen with rx_valid
    int         chk_seen = 0;
    int         frame_seen = 0;
    logic [7:0] drop_seen = '0;
    logic [7:0] exp_drops;
    logic [31:0] lfsr_state;

    assign uart_rx = loopback ? uart_tx : serial_line;

    tile i_dut (
        .clk, .rst_n, .uart_rx, .uart_tx, .tx_valid, .tx_op, .tx_dest, .tx_payload,
        .tx_full, .rx_valid, .rx_op, .rx_dest, .rx_payload, .chk_err, .frame_err,
        .drop_count
    );

    always #4 clk = ~clk;

    // Outputs are sampled on the falling edge, away from the driving edge
    always @(negedge clk) begin
        if (rx_valid) rx_q.push_back(flit_t'({rx_op, rx_dest, rx_payload}));
        if (chk_err) chk_seen++;
        if (frame_err) frame_seen++;
        drop_seen <= drop_count;
    end

    // ##########################################################
    // Checks and helpers
    // ##########################################################
    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_flag(string name, logic exp, logic got);
        if (got !== exp) fail_now($sformatf("FAILED %s: expected %b, got %b", name, exp, got));
    endtask

    task automatic check_count(string name, logic [7:0] exp, logic [7:0] got);
        if (got !== exp) fail_now($sformatf("FAILED %s: expected %0d, got %0d", name, exp, got));
    endtask

    task automatic check_flit(string name, flit_op_e exp_op, node_id_t exp_dest,
                              payload_t exp_payload, flit_t got);
        if (got.op !== exp_op || got.dest !== exp_dest || got.payload !== exp_payload) begin
            fail_now($sformatf("FAILED %s: expected op %0d dest %0d payload %h, %s",
                name, exp_op, exp_dest, exp_payload,
                $sformatf("got op %0d dest %0d payload %h", got.op, got.dest, got.payload)));
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
    endtask

    task automatic set_loopback(logic on);
        @(posedge clk);
        loopback <= on;
    endtask

    task automatic settle(int cycles);
        repeat (cycles) @(posedge clk);
    endtask

    task automatic hold_bit(logic b);
        @(posedge clk);
        serial_line <= b;
        repeat (`CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    // Start bit, LSB first data, stop bit, then one idle bit
    task automatic send_serial(logic [7:0] data, logic stop_bit);
        hold_bit(1'b0);
        for (int i = 0; i < 8; i++) hold_bit(data[i]);
        hold_bit(stop_bit);
        hold_bit(1'b1);
    endtask

    task automatic queue_flit(flit_op_e op, node_id_t dest, payload_t payload);
        @(posedge clk);
        tx_valid   <= 1'b1;
        tx_op      <= op;
        tx_dest    <= dest;
        tx_payload <= payload;
        @(posedge clk);
        tx_valid   <= 1'b0;
    endtask

    task automatic take_flit(string name, output flit_t f);
        int waited;
        waited = 0;
        while (rx_q.size() == 0) begin
            if (waited == FLIT_TIMEOUT) begin
                fail_now($sformatf("%s: no rx_valid before timeout", name));
            end
            @(posedge clk);
            waited++;
        end
        f = rx_q.pop_front();
    endtask

    task automatic expect_silence(string name, int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            if (rx_q.size() != 0) begin
                fail_now($sformatf("%s: a flit was delivered unexpectedly", name));
            end
        end
    endtask

    task automatic wait_err_pulse(string name, logic frame, int target);
        int waited;
        waited = 0;
        while ((frame ? frame_seen : chk_seen) < target) begin
            if (waited == FLIT_TIMEOUT) begin
                fail_now($sformatf("%s: expected error pulse never came", name));
            end
            @(posedge clk);
            waited++;
        end
    endtask

    task automatic wait_drop(string name, logic [7:0] target);
        int waited;
        waited = 0;
        while (drop_seen != target) begin
            if (waited == FLIT_TIMEOUT) begin
                fail_now($sformatf("%s: drop_count did not advance", name));
            end
            @(posedge clk);
            waited++;
        end
    endtask

    // ##########################################################
    // Directed tests
    // ##########################################################
    task automatic test_reset();
        @(negedge clk);
        check_flag("reset uart_tx", 1'b1, uart_tx);
        check_flag("reset tx_full", 1'b0, tx_full);
        check_flag("reset rx_valid", 1'b0, rx_valid);
        check_flag("reset chk_err", 1'b0, chk_err);
        check_flag("reset frame_err", 1'b0, frame_err);
        check_count("reset drop_count", 8'd0, drop_count);
    endtask

    task automatic test_loopback();
        flit_t f;
        set_loopback(1'b1);
        queue_flit(OP_WRITE, `NODE_ID, 12'h5a3);
        take_flit("loopback", f);
        check_flit("loopback", OP_WRITE, `NODE_ID, 12'h5a3, f);
    endtask

    task automatic test_addr_filter();
        queue_flit(OP_READ, 2'd2, 12'h0f0);
        exp_drops = exp_drops + 8'd1;
        expect_silence("addr_filter", FLIT_TIMEOUT);
        check_count("addr_filter drop_count", exp_drops, drop_seen);
    endtask

    task automatic test_checksum();
        logic [7:0] hi;
        logic [7:0] lo;
        flit_t f;
        int base;
        set_loopback(1'b0);
        hi = {OP_NOTIFY, `NODE_ID, 4'h3};
        lo = 8'h9c;
        base = chk_seen;
        send_serial(hi, 1'b1);
        send_serial(lo, 1'b1);
        send_serial(hi ^ lo ^ 8'h5a, 1'b1);   // Corrupted checksum
        wait_err_pulse("checksum", 1'b0, base + 1);
        settle(4);
        check_flag("checksum rx_valid", 1'b0, rx_q.size() != 0);
        send_serial(hi, 1'b1);
        send_serial(lo, 1'b1);
        send_serial(hi ^ lo, 1'b1);
        take_flit("checksum recovery", f);
        check_flit("checksum recovery", OP_NOTIFY, `NODE_ID, 12'h39c, f);
    endtask

    task automatic test_framing();
        logic [7:0] hi;
        logic [7:0] lo;
        flit_t f;
        int base;
        set_loopback(1'b0);
        hi = {OP_RESP, `NODE_ID, 4'hb};
        lo = 8'h27;
        base = frame_seen;
        send_serial(hi, 1'b1);
        send_serial(lo, 1'b1);
        send_serial(hi ^ lo, 1'b0);   // Good checksum but low stop bit
        wait_err_pulse("framing", 1'b1, base + 1);
        settle(4);
        check_flag("framing rx_valid", 1'b0, rx_q.size() != 0);
        send_serial(hi, 1'b1);
        send_serial(lo, 1'b1);
        send_serial(hi ^ lo, 1'b1);
        take_flit("framing recovery", f);
        check_flit("framing recovery", OP_RESP, `NODE_ID, 12'hb27, f);
    endtask

    task automatic test_queue_depth();
        flit_t f;
        set_loopback(1'b1);
        for (int i = 0; i <= `TX_DEPTH; i++) begin
            @(posedge clk);
            tx_valid   <= 1'b1;
            tx_op      <= flit_op_e'(i[1:0]);
            tx_dest    <= `NODE_ID;
            tx_payload <= payload_t'(12'h100 + i);
            @(negedge clk);
            check_flag($sformatf("queue_depth tx_full %0d", i), i == `TX_DEPTH, tx_full);
        end
        @(posedge clk);
        tx_valid <= 1'b0;
        for (int i = 0; i < `TX_DEPTH; i++) begin
            take_flit("queue_depth", f);
            check_flit("queue_depth", flit_op_e'(i[1:0]), `NODE_ID, payload_t'(12'h100 + i), f);
        end
        expect_silence("queue_depth extra write", FLIT_TIMEOUT);
    endtask

    task automatic test_random();
        logic [15:0] bits;
        flit_op_e op;
        node_id_t dest;
        payload_t payload;
        flit_t f;
        set_loopback(1'b1);
        for (int n = 0; n < 20; n++) begin
            take_bits(16, bits);
            op      = flit_op_e'(bits[15:14]);
            dest    = bits[13:12];
            payload = bits[11:0];
            queue_flit(op, dest, payload);
            if (dest == `NODE_ID) begin
                take_flit("random", f);
                check_flit("random", op, dest, payload, f);
            end else begin
                exp_drops = exp_drops + 8'd1;
                wait_drop("random", exp_drops);
                check_flag("random rx_valid", 1'b0, rx_q.size() != 0);
            end
        end
        check_count("random drop_count", exp_drops, drop_seen);
    endtask

    initial begin
        rst_n       = 1'b0;
        loopback    = 1'b1;
        serial_line = 1'b1;   // Line idles high
        tx_valid    = 1'b0;
        tx_op       = OP_WRITE;
        tx_dest     = '0;
        tx_payload  = '0;
        lfsr_state  = 32'h4916;
        exp_drops   = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        test_reset();
        test_loopback();
        test_addr_filter();
        test_checksum();
        test_framing();
        test_queue_depth();
        test_random();

        $display("All tests passed!");
        $finish;
    end
endmodule

//--- verilog.f
+incdir+source
source/phy_pkg.sv
source/noc_pkg.sv
source/baud_timer.sv
source/link_ctrl.sv
source/byte_shifter.sv
source/flit_codec.sv
source/endpoint.sv
source/tile.sv
test/tile_tb.sv

//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary -j 0 --top-module tile_tb -f verilog.f -o tile_sim
	@out="$$(./obj_dir/tile_sim)"; echo "$$out"; echo "$$out" | grep -qF "All tests passed!"

lint:
	verilator --lint-only --timing --top-module tile_tb -f verilog.f

clean:
	rm -rf obj_dir
